//--- filelist.f
common/jtag_slave_pkg.sv
hw/axi_slave/axi_wr_decode.sv
hw/axi_slave/axi_rd_result.sv
hw/jtag_ctrl_regs.sv
hw/cmd_queue.sv
hw/tck_gen.sv
hw/jtag_slave_top.sv
test/jtag_slave_sva.sv
test/tb_jtag_slave.sv

//--- run.sh
#!/bin/sh
# build and run with Verilator; the log is searched for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_jtag_slave \
    -f filelist.f -o sim_jtag_slave \
    && ./obj_dir/sim_jtag_slave > sim.log 2>&1 \
    && cat sim.log \
    && ! grep -q "Errors found" sim.log \
    && echo "simulation passed" \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

//--- test/tb_jtag_slave.sv
`default_nettype none

module tb_jtag_slave;
    timeunit 1ns;
    timeprecision 100ps;
    import jtag_slave_pkg::*;

    localparam int          timeout_cycles = 2000;
    localparam logic [31:0] lfsr_seed      = 32'h6c86_10d5;

    logic clk, jtag_rstn_sync;
    id_t wr_addr_id, wr_back_id, rd_addr_id, rd_back_id;
    addr_t wr_addr, rd_addr;
    burst_t wr_addr_burst, rd_addr_burst;
    logic wr_addr_valid, wr_addr_ready, wr_data_last, wr_data_valid, wr_data_ready;
    data_t wr_data, rd_data;
    strb_t wr_strb;
    resp_t wr_back_resp, rd_data_resp;
    logic wr_back_valid, wr_back_ready, rd_addr_valid, rd_addr_ready;
    len_t rd_addr_len;
    logic rd_data_last, rd_data_valid, rd_data_ready;
    cmd_word_t cmd_word;
    logic cmd_valid, cmd_ready, cmd_done, tck, jtag_rd_en, jtag_wr_en, power_on;

    int          errors;
    int          timeouts;
    int          first_stall;   // beat index of the first write stall
    logic [31:0] lfsr_state;
    data_t       rd_q[$];
    resp_t       rd_resp_q[$];
    cmd_word_t   popped[$];

    jtag_slave_top i_dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    task automatic write_burst(input addr_t addr, input burst_t burst, input strb_t strb,
                               input data_t words[$], output resp_t resp);
        int          t;
        logic [31:0] id;
        resp = 2'b11;
        take_bits(4, id);
        @(posedge clk);
        wr_addr       <= addr;
        wr_addr_burst <= burst;
        wr_addr_id    <= id[3:0];
        wr_addr_valid <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!wr_addr_ready && t < timeout_cycles);
        @(posedge clk);
        wr_addr_valid <= 1'b0;
        if (t >= timeout_cycles) begin
            timed_out("write address ready");
            return;
        end
        for (int i = 0; i < words.size(); i++) begin
            wr_data       <= words[i];
            wr_strb       <= strb;
            wr_data_last  <= (i == words.size() - 1);
            wr_data_valid <= 1'b1;
            t = 0;
            do begin
                @(negedge clk);
                t++;
                if (!wr_data_ready && first_stall < 0 && addr == addr_cmd)
                    first_stall = i;
            end while (!wr_data_ready && t < timeout_cycles);
            @(posedge clk);
            if (t >= timeout_cycles) begin
                wr_data_valid <= 1'b0;
                timed_out("write data ready");
                return;
            end
        end
        wr_data_valid <= 1'b0;
        wr_data_last  <= 1'b0;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!wr_back_valid && t < timeout_cycles);
        if (t >= timeout_cycles) begin
            timed_out("write response");
            return;
        end
        resp = wr_back_resp;
        check_value("write response id", 32'(wr_back_id), 32'(id[3:0]));
        @(posedge clk);
    endtask

    task automatic read_burst(input addr_t addr, input len_t len, input logic stall);
        int          t;
        logic        done;
        logic [31:0] b;
        logic [31:0] id;
        rd_q.delete();
        rd_resp_q.delete();
        take_bits(4, id);
        @(posedge clk);
        rd_addr       <= addr;
        rd_addr_len   <= len;
        rd_addr_burst <= burst_incr;
        rd_addr_id    <= id[3:0];
        rd_addr_valid <= 1'b1;
        t = 0;
        do begin
            @(negedge clk);
            t++;
        end while (!rd_addr_ready && t < timeout_cycles);
        @(posedge clk);
        rd_addr_valid <= 1'b0;
        if (t >= timeout_cycles) begin
            timed_out("read address ready");
            return;
        end
        done = 1'b0;
        t    = 0;
        while (!done && t < timeout_cycles) begin
            take_bits(1, b);
            rd_data_ready <= stall ? b[0] : 1'b1;   // random stalls
            @(negedge clk);
            t++;
            if (rd_data_valid && rd_data_ready) begin
                rd_q.push_back(rd_data);
                rd_resp_q.push_back(rd_data_resp);
                check_value("read data id", 32'(rd_back_id), 32'(id[3:0]));
                done = rd_data_last;
                t    = 0;
            end
            @(posedge clk);
        end
        rd_data_ready <= 1'b0;
        if (!done)
            timed_out("read data");
    endtask

    task automatic read_check(input string what, input addr_t addr, input resp_t exp_resp,
                              input data_t exp_data);
        read_burst(addr, 8'd0, 1'b1);
        check_value({what, " beat count"}, 32'(rd_q.size()), 32'd1);
        if (rd_q.size() == 1) begin
            check_value({what, " resp"}, 32'(rd_resp_q[0]), 32'(exp_resp));
            check_value({what, " data"}, rd_q[0], exp_data);
        end
    endtask

    initial begin
        data_t       words[$];
        data_t       exp;
        logic [31:0] r;
        logic [31:0] s;
        resp_t       resp;
        int          t;
        clk            = 1'b0;
        jtag_rstn_sync = 1'b0;
        wr_addr_id     = '0;
        wr_addr        = '0;
        wr_addr_burst  = '0;
        wr_addr_valid  = 1'b0;
        wr_data        = '0;
        wr_strb        = '0;
        wr_data_last   = 1'b0;
        wr_data_valid  = 1'b0;
        wr_back_ready  = 1'b1;
        rd_addr_id     = '0;
        rd_addr        = '0;
        rd_addr_len    = '0;
        rd_addr_burst  = '0;
        rd_addr_valid  = 1'b0;
        rd_data_ready  = 1'b0;
        cmd_ready      = 1'b0;
        cmd_done       = 1'b0;
        errors         = 0;
        timeouts       = 0;
        first_stall    = -1;
        lfsr_state     = lfsr_seed;
        repeat (10) @(posedge clk);
        jtag_rstn_sync <= 1'b1;

        // small speed phases so tck toggles often
        take_bits(32, r);
        take_bits(4, s);
        words = '{r & 32'h000f_000f};
        exp   = 32'h0001_0001;
        for (int i = 0; i < 4; i++)
            if (s[i]) exp[8*i +: 8] = words[0][8*i +: 8];
        write_burst(addr_speed, burst_fixed, s[3:0], words, resp);
        check_value("speed write resp", 32'(resp), 32'(resp_okay));
        read_check("speed read", addr_speed, resp_okay, exp);
        repeat (200) @(posedge clk);

        words = '{32'h1};
        write_burst(addr_power, burst_fixed, 4'hf, words, resp);
        check_value("power_on after set", 32'(power_on), 32'd1);
        read_check("power read", addr_power, resp_okay, 32'd1);
        words = '{32'h0};
        write_burst(addr_power, burst_fixed, 4'b1110, words, resp);
        read_check("power kept", addr_power, resp_okay, 32'd1);

        words = '{32'h0};
        write_burst(32'd1, burst_incr, 4'hf, words, resp);
        check_value("write addr 1 resp", 32'(resp), 32'(resp_slverr));
        write_burst(32'd9, burst_incr, 4'hf, words, resp);
        check_value("write addr 9 resp", 32'(resp), 32'(resp_slverr));
        write_burst(addr_state, 2'd2, 4'hf, words, resp);
        check_value("burst code 2 resp", 32'(resp), 32'(resp_slverr));
        read_check("read addr 3", addr_cmd, resp_slverr, rd_error_data);
        read_check("read addr 9", 32'd9, resp_slverr, rd_error_data);
        read_burst(addr_state, 8'd3, 1'b1);
        check_value("incr read beats", 32'(rd_q.size()), 32'd4);
        for (int i = 0; i < rd_q.size(); i++) begin
            check_value("incr read resp", 32'(rd_resp_q[i]),
                        32'(i == 0 ? resp_okay : resp_slverr));
            check_value("incr read data", rd_q[i], i == 0 ? 32'h0002_0000 : rd_error_data);
        end

        // ten words into an eight-entry queue with the consumer held off
        words.delete();
        for (int i = 0; i < 10; i++) begin
            take_bits(32, r);
            words.push_back(r);
        end
        first_stall = -1;
        popped.delete();
        fork
            write_burst(addr_cmd, burst_fixed, 4'hf, words, resp);
            begin
                t = 0;
                while (first_stall < 0 && t < timeout_cycles) begin
                    @(negedge clk);
                    t++;
                end
                if (first_stall < 0)
                    timed_out("queue stall");
                check_value("stall beat", 32'(first_stall), 32'd8);
                read_check("status full", addr_state, resp_okay, 32'h0004_0000);
                @(posedge clk);
                cmd_ready <= 1'b1;
            end
            begin : collect_pops
                int n;
                n = 0;
                while (popped.size() < 10 && n < timeout_cycles) begin
                    @(negedge clk);
                    n++;
                    if (cmd_valid && cmd_ready)
                        popped.push_back(cmd_word);
                end
                if (popped.size() < 10)
                    timed_out("queue drain");
            end
        join
        check_value("queue write resp", 32'(resp), 32'(resp_okay));
        for (int i = 0; i < popped.size(); i++)
            check_value("popped word", popped[i], words[i]);
        @(posedge clk);
        cmd_ready <= 1'b0;
        read_check("status empty", addr_state, resp_okay, 32'h0002_0000);

        words = '{32'h1111_1111, 32'h2222_2222, 32'h3333_3333};
        write_burst(addr_cmd, burst_fixed, 4'hf, words, resp);
        @(negedge clk);
        check_value("cmd_valid before clear", 32'(cmd_valid), 32'd1);
        words = '{32'h0001_0000};
        write_burst(addr_state, burst_fixed, 4'hf, words, resp);
        @(negedge clk);
        check_value("cmd_valid after clear", 32'(cmd_valid), 32'd0);
        read_check("status after clear", addr_state, resp_okay, 32'h0002_0000);

        $display("closing: %0d check errors, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/jtag_slave_sva.sv
`default_nettype none

module jtag_slave_sva (
    input wire                           clk,
    input wire                           jtag_rstn_sync,
    input wire                           wr_addr_ready,
    input wire                           rd_addr_ready,
    input wire                           wr_back_valid,
    input wire                           rd_addr_valid,
    input wire jtag_slave_pkg::len_t     rd_addr_len,
    input wire                           rd_data_valid,
    input wire                           rd_data_ready,
    input wire                           rd_data_last,
    input wire                           cmd_valid,
    input wire                           power_on,
    input wire                           tck,
    input wire                           jtag_rd_en,
    input wire                           jtag_wr_en,
    input wire jtag_slave_pkg::tck_cfg_t tck_cfg
);
    timeunit 1ns;
    timeprecision 100ps;
    import jtag_slave_pkg::*;

    logic    tck_q;
    period_t run_len;   // cycles of the phase that just ended
    period_t exp_high;
    period_t exp_low;
    len_t    len_l;
    len_t    beat;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            tck_q    <= 1'b0;
            run_len  <= '0;
            exp_high <= 16'd1;
            exp_low  <= 16'd1;
            len_l    <= '0;
            beat     <= '0;
        end else begin
            tck_q   <= tck;
            run_len <= (tck == tck_q) ? run_len + 16'd1 : 16'd1;
            // phase lengths are taken at the edge that starts the phase
            if (!tck)
                exp_high <= (tck_cfg.high == '0) ? 16'd1 : tck_cfg.high;
            else
                exp_low <= (tck_cfg.low == '0) ? 16'd1 : tck_cfg.low;
            if (rd_addr_valid && rd_addr_ready) begin
                len_l <= rd_addr_len;
                beat  <= '0;
            end else if (rd_data_valid && rd_data_ready) begin
                beat <= beat + 8'd1;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        !jtag_rstn_sync |-> wr_addr_ready && rd_addr_ready && !wr_back_valid
                            && !rd_data_valid && !cmd_valid && !power_on && !tck)
        else $error("outputs not at their reset values during reset");

    a_tck_phase: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        (tck != tck_q) |-> run_len == (tck_q ? exp_high : exp_low))
        else $error("tck phase length differs from the speed register");

    a_sample_pulse: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        jtag_rd_en == (tck && !tck_q))
        else $error("jtag_rd_en does not follow the rising tck edge");

    a_drive_pulse: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        jtag_wr_en == (!tck && tck_q))
        else $error("jtag_wr_en does not follow the falling tck edge");

    a_read_last: assert property (@(posedge clk) disable iff (!jtag_rstn_sync)
        rd_data_valid |-> rd_data_last == (beat == len_l))
        else $error("rd_data_last not on the final beat of the burst");

endmodule

bind jtag_slave_top jtag_slave_sva i_sva (.*);

`default_nettype wire

//--- hw/jtag_slave_top.sv
`default_nettype none

module jtag_slave_top (
    input  wire                           clk,
    input  wire                           jtag_rstn_sync,
    input  wire jtag_slave_pkg::id_t      wr_addr_id,
    input  wire jtag_slave_pkg::addr_t    wr_addr,
    input  wire jtag_slave_pkg::burst_t   wr_addr_burst,
    input  wire                           wr_addr_valid,
    output logic                          wr_addr_ready,
    input  wire jtag_slave_pkg::data_t    wr_data,
    input  wire jtag_slave_pkg::strb_t    wr_strb,
    input  wire                           wr_data_last,
    input  wire                           wr_data_valid,
    output logic                          wr_data_ready,
    output jtag_slave_pkg::id_t           wr_back_id,
    output jtag_slave_pkg::resp_t         wr_back_resp,
    output logic                          wr_back_valid,
    input  wire                           wr_back_ready,
    input  wire jtag_slave_pkg::id_t      rd_addr_id,
    input  wire jtag_slave_pkg::addr_t    rd_addr,
    input  wire jtag_slave_pkg::len_t     rd_addr_len,
    input  wire jtag_slave_pkg::burst_t   rd_addr_burst,
    input  wire                           rd_addr_valid,
    output logic                          rd_addr_ready,
    output jtag_slave_pkg::id_t           rd_back_id,
    output jtag_slave_pkg::data_t         rd_data,
    output jtag_slave_pkg::resp_t         rd_data_resp,
    output logic                          rd_data_last,
    output logic                          rd_data_valid,
    input  wire                           rd_data_ready,
    output jtag_slave_pkg::cmd_word_t     cmd_word,
    output logic                          cmd_valid,
    input  wire                           cmd_ready,
    input  wire                           cmd_done,
    output logic                          tck,
    output logic                          jtag_rd_en,
    output logic                          jtag_wr_en,
    output logic                          power_on
);
    import jtag_slave_pkg::*;

    reg_wr_t   reg_wr;
    cmd_word_t cmd_push_word;
    tck_cfg_t  tck_cfg;
    data_t     status_word;
    logic      cmd_push;
    logic      cmd_clear;
    logic      cmd_full;
    logic      cmd_empty;

    axi_wr_decode i_wr_decode (.*);

    axi_rd_result i_rd_result (.*);

    jtag_ctrl_regs i_regs (.*);

    cmd_queue #(
        .depth(cmd_depth)
    ) i_cmd_queue (
        .clk           (clk),
        .jtag_rstn_sync(jtag_rstn_sync),
        .clear         (cmd_clear),
        .push          (cmd_push),
        .push_word     (cmd_push_word),
        .pop_ready     (cmd_ready),     // tap engine pops the head
        .head          (cmd_word),
        .head_valid    (cmd_valid),
        .full          (cmd_full),
        .empty         (cmd_empty)
    );

    tck_gen i_tck_gen (.*);

endmodule

`default_nettype wire

//--- hw/tck_gen.sv
`default_nettype none

module tck_gen (
    input  wire                           clk,
    input  wire                           jtag_rstn_sync,
    input  wire jtag_slave_pkg::tck_cfg_t tck_cfg,
    output logic                          tck,
    output logic                          jtag_rd_en,
    output logic                          jtag_wr_en
);
    import jtag_slave_pkg::*;

    period_t cnt;
    period_t phase_len;   // length of the running phase
    period_t high_len;
    period_t low_len;
    logic    phase_end;

    // a programmed 0 runs as one cycle
    assign high_len  = (tck_cfg.high == '0) ? 16'd1 : tck_cfg.high;
    assign low_len   = (tck_cfg.low == '0) ? 16'd1 : tck_cfg.low;
    assign phase_end = (cnt == phase_len);

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            tck        <= 1'b0;
            cnt        <= 16'd1;
            phase_len  <= period_reset;
            jtag_rd_en <= 1'b0;
            jtag_wr_en <= 1'b0;
        end else begin
            jtag_rd_en <= phase_end && !tck;  // tdo sample on rise
            jtag_wr_en <= phase_end && tck;   // tdi/tms drive on fall
            if (phase_end) begin
                tck       <= !tck;
                cnt       <= 16'd1;
                phase_len <= tck ? low_len : high_len;  // new cfg picked up here
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cmd_queue.sv
`default_nettype none

module cmd_queue #(
    parameter int depth = 8   // power of two
) (
    input  wire                             clk,
    input  wire                             jtag_rstn_sync,
    input  wire                             clear,
    input  wire                             push,
    input  wire jtag_slave_pkg::cmd_word_t  push_word,
    input  wire                             pop_ready,
    output jtag_slave_pkg::cmd_word_t       head,
    output logic                            head_valid,
    output logic                            full,
    output logic                            empty
);
    import jtag_slave_pkg::*;

    localparam int ptr_w = $clog2(depth);

    cmd_word_t        mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (ptr_w + 1)'(depth));
    assign do_push = push && !full;       // dropped when full
    assign do_pop  = pop_ready && !empty;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= push_word;
    end

    assign head       = mem[rd_ptr];    // show-ahead
    assign head_valid = !empty;

endmodule

`default_nettype wire

//--- hw/jtag_ctrl_regs.sv
`default_nettype none

module jtag_ctrl_regs (
    input  wire                           clk,
    input  wire                           jtag_rstn_sync,
    input  wire jtag_slave_pkg::reg_wr_t  reg_wr,
    input  wire                           cmd_empty,
    input  wire                           cmd_full,
    input  wire                           cmd_done,
    output logic                          cmd_push,
    output jtag_slave_pkg::cmd_word_t     cmd_push_word,
    output logic                          cmd_clear,
    output jtag_slave_pkg::data_t         status_word,
    output jtag_slave_pkg::tck_cfg_t      tck_cfg,
    output logic                          power_on
);
    import jtag_slave_pkg::*;

    logic clear_q;
    logic wr_state;
    logic wr_speed;
    logic wr_power;

    assign wr_state = reg_wr.enable && (reg_wr.addr == addr_state);
    assign wr_speed = reg_wr.enable && (reg_wr.addr == addr_speed);
    assign wr_power = reg_wr.enable && (reg_wr.addr == addr_power);

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            clear_q <= 1'b0;
            tck_cfg <= '{high: period_reset, low: period_reset};
            power_on <= 1'b0;
        end else begin
            // only the clear bit is writable here, and only for one cycle
            clear_q <= wr_state && reg_wr.strb[bit_cmd_clear / 8]
                    && reg_wr.data[bit_cmd_clear];
            if (wr_speed) begin
                for (int i = 0; i < 4; i++) begin
                    if (reg_wr.strb[i])
                        tck_cfg[8*i +: 8] <= reg_wr.data[8*i +: 8];
                end
            end
            if (wr_power && reg_wr.strb[0])
                power_on <= reg_wr.data[0];
        end
    end

    assign cmd_clear = clear_q;

    // queue words go in whole, strobes ignored
    assign cmd_push      = reg_wr.enable && (reg_wr.addr == addr_cmd);
    assign cmd_push_word = cmd_word_t'(reg_wr.data);

    always_comb begin
        status_word                = '0;  // reserved bits
        status_word[bit_cmd_clear] = clear_q;
        status_word[bit_cmd_empty] = cmd_empty;
        status_word[bit_cmd_full]  = cmd_full;
        status_word[bit_cmd_done]  = cmd_done;
    end

endmodule

`default_nettype wire

//--- hw/axi_slave/axi_rd_result.sv
`default_nettype none

module axi_rd_result (
    input  wire                          clk,
    input  wire                          jtag_rstn_sync,
    input  wire jtag_slave_pkg::id_t     rd_addr_id,
    input  wire jtag_slave_pkg::addr_t   rd_addr,
    input  wire jtag_slave_pkg::len_t    rd_addr_len,
    input  wire jtag_slave_pkg::burst_t  rd_addr_burst,
    input  wire                          rd_addr_valid,
    output logic                         rd_addr_ready,
    output jtag_slave_pkg::id_t          rd_back_id,
    output jtag_slave_pkg::data_t        rd_data,
    output jtag_slave_pkg::resp_t        rd_data_resp,
    output logic                         rd_data_last,
    output logic                         rd_data_valid,
    input  wire                          rd_data_ready,
    input  wire jtag_slave_pkg::data_t   status_word,
    input  wire jtag_slave_pkg::tck_cfg_t tck_cfg,
    input  wire                          power_on
);
    import jtag_slave_pkg::*;

    rd_state_e state;
    rd_state_e state_nxt;
    id_t       id_q;
    addr_t     addr_q;
    len_t      len_q;
    burst_t    burst_q;
    len_t      beat_cnt;
    logic      err_q;
    logic      beat_err;
    logic      beat_bad;
    logic      addr_hs;
    logic      data_hs;
    data_t     reg_sel;

    assign addr_hs = rd_addr_valid && rd_addr_ready;
    assign data_hs = rd_data_valid && rd_data_ready;

    // rd_data is also a port name, hence the scoped state literal
    always_comb begin
        state_nxt = state;
        case (state)
            rd_idle:                 if (addr_hs) state_nxt = jtag_slave_pkg::rd_data;
            jtag_slave_pkg::rd_data: if (data_hs && rd_data_last) state_nxt = rd_idle;
            default:                 state_nxt = rd_idle;
        endcase
    end

    // addr_cmd is write only on this side
    assign beat_err = (burst_q != burst_fixed && burst_q != burst_incr)
                   || (addr_q > addr_last)
                   || (addr_q inside {32'd1, 32'd2, addr_cmd, 32'd5, 32'd6});
    assign beat_bad = beat_err || err_q;

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state    <= rd_idle;
            beat_cnt <= '0;
            err_q    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (addr_hs) begin
                beat_cnt <= '0;
                err_q    <= 1'b0;
            end else if (data_hs) begin
                beat_cnt <= beat_cnt + 1'b1;
                err_q    <= beat_bad;   // sticky for later beats
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_hs) begin
            id_q    <= rd_addr_id;
            addr_q  <= rd_addr;
            len_q   <= rd_addr_len;
            burst_q <= rd_addr_burst;
        end else if (data_hs && burst_q == burst_incr) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_comb begin
        case (addr_q)
            addr_state: reg_sel = status_word;
            addr_speed: reg_sel = tck_cfg;          // high phase in upper half
            addr_power: reg_sel = {31'd0, power_on};
            default:    reg_sel = rd_error_data;
        endcase
    end

    assign rd_addr_ready = (state == rd_idle);
    assign rd_data_valid = (state == jtag_slave_pkg::rd_data);  // every register is ready at once
    assign rd_data_last  = rd_data_valid && (beat_cnt == len_q);
    assign rd_data       = beat_bad ? rd_error_data : reg_sel;
    assign rd_data_resp  = beat_bad ? resp_slverr : resp_okay;
    assign rd_back_id    = id_q;

endmodule

`default_nettype wire

//--- hw/axi_slave/axi_wr_decode.sv
`default_nettype none

module axi_wr_decode (
    input  wire                        clk,
    input  wire                        jtag_rstn_sync,
    input  wire jtag_slave_pkg::id_t   wr_addr_id,
    input  wire jtag_slave_pkg::addr_t wr_addr,
    input  wire jtag_slave_pkg::burst_t wr_addr_burst,
    input  wire                        wr_addr_valid,
    output logic                       wr_addr_ready,
    input  wire jtag_slave_pkg::data_t wr_data,
    input  wire jtag_slave_pkg::strb_t wr_strb,
    input  wire                        wr_data_last,
    input  wire                        wr_data_valid,
    output logic                       wr_data_ready,
    output jtag_slave_pkg::id_t        wr_back_id,
    output jtag_slave_pkg::resp_t      wr_back_resp,
    output logic                       wr_back_valid,
    input  wire                        wr_back_ready,
    input  wire                        cmd_full,
    output jtag_slave_pkg::reg_wr_t    reg_wr
);
    import jtag_slave_pkg::*;

    wr_state_e state;
    wr_state_e state_nxt;
    id_t       id_q;
    addr_t     addr_q;
    burst_t    burst_q;
    logic      err_q;
    logic      beat_err;
    logic      addr_hs;
    logic      data_hs;

    assign addr_hs = wr_addr_valid && wr_addr_ready;
    assign data_hs = wr_data_valid && wr_data_ready;

    // the data state literal shares its name with the wr_data port
    always_comb begin
        state_nxt = state;
        case (state)
            wr_idle:                 if (addr_hs) state_nxt = jtag_slave_pkg::wr_data;
            jtag_slave_pkg::wr_data: if (data_hs && wr_data_last) state_nxt = wr_resp;
            wr_resp:                 if (wr_back_ready) state_nxt = wr_idle;
            default:                 state_nxt = wr_idle;
        endcase
    end

    // bad burst code, out of map, or a dropped / read-only address
    assign beat_err = (burst_q != burst_fixed && burst_q != burst_incr)
                   || (addr_q > addr_last)
                   || (addr_q inside {32'd1, 32'd2, 32'd5, 32'd6});

    always_ff @(posedge clk or negedge jtag_rstn_sync) begin
        if (!jtag_rstn_sync) begin
            state <= wr_idle;
            err_q <= 1'b0;
        end else begin
            state <= state_nxt;
            if (addr_hs)
                err_q <= 1'b0;
            else if (data_hs && beat_err)
                err_q <= 1'b1;  // held to the response
        end
    end

    always_ff @(posedge clk) begin
        if (addr_hs) begin
            id_q    <= wr_addr_id;
            addr_q  <= wr_addr;
            burst_q <= wr_addr_burst;
        end else if (data_hs && burst_q == burst_incr) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    assign wr_addr_ready = (state == wr_idle);
    // queue back-pressure stalls the beat at addr_cmd
    assign wr_data_ready = (state == jtag_slave_pkg::wr_data)
                        && !(addr_q == addr_cmd && cmd_full);
    assign wr_back_valid = (state == wr_resp);
    assign wr_back_id    = id_q;
    assign wr_back_resp  = err_q ? resp_slverr : resp_okay;

    assign reg_wr = '{enable: data_hs && !beat_err, addr: addr_q, data: wr_data, strb: wr_strb};

endmodule

`default_nettype wire

//--- common/jtag_slave_pkg.sv
`default_nettype none

package jtag_slave_pkg;

    localparam int id_width = 4;

    typedef logic [id_width-1:0] id_t;
    typedef logic [31:0]         addr_t;    // word address
    typedef logic [31:0]         data_t;
    typedef logic [3:0]          strb_t;
    typedef logic [7:0]          len_t;     // beats minus one
    typedef logic [1:0]          burst_t;
    typedef logic [1:0]          resp_t;
    typedef logic [15:0]         period_t;  // tck phase in clk cycles
    typedef logic [3:0]          cmd_t;
    typedef logic [27:0]         cycle_t;

    localparam burst_t burst_fixed = 2'd0;
    localparam burst_t burst_incr  = 2'd1;  // codes 2 and 3 are illegal

    localparam resp_t resp_okay   = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // slave register map
    localparam addr_t addr_state = 32'd0;
    localparam addr_t addr_cmd   = 32'd3;   // command queue, write only
    localparam addr_t addr_speed = 32'd4;
    localparam addr_t addr_power = 32'd7;
    localparam addr_t addr_last  = 32'd7;

    localparam int bit_cmd_clear = 16;      // self-clearing
    localparam int bit_cmd_empty = 17;
    localparam int bit_cmd_full  = 18;
    localparam int bit_cmd_done  = 24;

    localparam period_t period_reset  = 16'd1;
    localparam data_t   rd_error_data = 32'hffff_ffff;
    localparam int      cmd_depth     = 8;  // queue entries

    typedef struct packed {
        cmd_t   cmd;
        cycle_t cycles;
    } cmd_word_t;

    typedef struct packed {
        logic  enable;                      // legal beat only
        addr_t addr;
        data_t data;
        strb_t strb;
    } reg_wr_t;

    typedef struct packed {
        period_t high;
        period_t low;
    } tck_cfg_t;

    typedef enum logic [1:0] {
        wr_idle,
        wr_data,
        wr_resp
    } wr_state_e;

    typedef enum logic {
        rd_idle,
        rd_data
    } rd_state_e;

endpackage

`default_nettype wire
